// File: build.f
tdc_pkg.sv
tdc_coarse_counter.sv
tdc_hit_capture.sv
tdc_tof_calc.sv
tdc_readout_fsm.sv
tdc_top.sv
tb_tdc_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the tdc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_tdc_top -f build.f
output=$(./obj_dir/Vtb_tdc_top)
echo "$output"

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

// File: tb_tdc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tdc_top;
    import tdc_pkg::*;

    localparam int MAX_HITS    = 5;
    localparam int RANGE_COUNT = 200;
    localparam int NUM_TESTS   = 6;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic               hit;
    logic [PHASE_W-1:0] phase;
    logic               tof_ready;
    logic [TOF_W-1:0]   tof_data;
    logic [NUM_W-1:0]   tof_num;
    logic               tof_last;
    logic               tof_valid;
    logic               busy;

    int                 errors;
    int                 checks;
    int                 hit_offs[$];   // cycles after start that carry a hit
    logic [TOF_W-1:0]   exp_words[$];  // modelled burst

    tdc_top #(
        .MAX_HITS    (MAX_HITS),
        .RANGE_COUNT (RANGE_COUNT)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // each test stays well under RANGE_COUNT + 100 cycles
    initial begin
        repeat (NUM_TESTS * (RANGE_COUNT + 100)) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    // --------------------------------------------------
    // checker and reference model
    // --------------------------------------------------
    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // twice the ones capped at 31
    function automatic logic [FINE_W-1:0] fine_ref(input logic [PHASE_W-1:0] ph);
        int v;
        v = 2 * $countones(ph);
        return (v > 31) ? 5'd31 : FINE_W'(v);
    endfunction

    function automatic logic [PHASE_W-1:0] thermo_phase();
        int n;
        n = $urandom % (PHASE_W + 1);
        return PHASE_W'((33'd1 << n) - 1);  // n ones from the bottom
    endfunction

    // --------------------------------------------------
    // stimulus and burst collection
    // --------------------------------------------------
    task automatic run_window(input int stray_start_at);
        logic [PHASE_W-1:0] ph;
        logic [TOF_W-1:0]   start_w;
        logic [TOF_W-1:0]   stop_w;
        logic [TOF_W-1:0]   diff_w;
        bit                 is_hit;
        exp_words.delete();
        ph      = thermo_phase();
        start_w = {COARSE_W'(0), fine_ref(ph)};
        @(posedge clk);
        start <= 1'b1;
        phase <= ph;
        @(negedge clk);
        check_val("busy", 32'(busy), 32'd0);  // start not sampled yet
        @(posedge clk);
        start <= 1'b0;
        for (int k = 1; k <= RANGE_COUNT; k++) begin
            ph     = thermo_phase();
            is_hit = 1'b0;
            foreach (hit_offs[j]) begin
                if (hit_offs[j] == k) begin
                    is_hit = 1'b1;
                end
            end
            hit   <= is_hit;
            phase <= ph;
            start <= (k == stray_start_at);
            if (is_hit && exp_words.size() < MAX_HITS) begin
                stop_w = {COARSE_W'(k), fine_ref(ph)};
                diff_w = stop_w - start_w;  // mod 2^19
                exp_words.push_back(diff_w);
            end
            if (k == 1) begin
                @(negedge clk);
                check_val("busy", 32'(busy), 32'd1);
            end
            @(posedge clk);
        end
        hit   <= 1'b0;
        start <= 1'b0;
    endtask

    task automatic collect_burst(output int waited);
        int               n_words;
        logic [TOF_W-1:0] want;
        n_words = (exp_words.size() == 0) ? 1 : exp_words.size();
        waited  = 0;
        @(negedge clk);
        while (!tof_valid && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (!tof_valid) begin
            errors++;
            $display("no tof_valid seen within 100 cycles of the window end");
        end else begin
            for (int w = 0; w < n_words; w++) begin
                want = (exp_words.size() == 0) ? NO_HIT_WORD : exp_words[w];
                check_val("tof_valid", 32'(tof_valid), 32'd1);
                check_val("tof_num", 32'(tof_num), 32'(exp_words.size()));
                check_val("tof_last", 32'(tof_last), 32'(w == n_words - 1));
                check_val("tof_data", 32'(tof_data), 32'(want));
                @(negedge clk);
            end
            check_val("tof_valid", 32'(tof_valid), 32'd0);  // burst over
            check_val("busy", 32'(busy), 32'd0);
        end
        @(posedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic test_reset_busy();
        int waited;
        @(negedge clk);
        check_val("tof_valid", 32'(tof_valid), 32'd0);
        check_val("tof_last", 32'(tof_last), 32'd0);
        check_val("busy", 32'(busy), 32'd0);
        check_val("tof_num", 32'(tof_num), 32'd0);
        @(posedge clk);
        hit_offs = {10};
        run_window(0);
        collect_burst(waited);
    endtask

    task automatic test_hits(input int stray_start_at);
        int waited;
        run_window(stray_start_at);
        collect_burst(waited);
    endtask

    task automatic test_ready_hold();
        int waited;
        tof_ready <= 1'b0;
        hit_offs = {30, 31, 140};
        run_window(0);
        repeat (50) begin
            @(negedge clk);
            check_val("tof_valid", 32'(tof_valid), 32'd0);
            @(posedge clk);
        end
        tof_ready <= 1'b1;
        collect_burst(waited);
        check_val("ready to valid cycles", 32'(waited), 32'd1);
    endtask

    task automatic test_ignored_inputs();
        hit_offs = {15, 60, 61};
        hit <= 1'b1;    // high in IDLE and through the start cycle
        test_hits(40);  // second start in the middle of MEASURE
    endtask

    initial begin
        int seed_ret;
        int errs;
        seed_ret  = $urandom(32'ha1202dd6);
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        start     = 1'b0;
        hit       = 1'b0;
        phase     = '0;
        tof_ready = 1'b1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        errs = errors;
        test_reset_busy();
        report_test("reset and busy", errs);
        errs = errors;
        hit_offs = {12, 77, 150};
        test_hits(0);
        report_test("three hits", errs);
        errs = errors;
        hit_offs = {};
        test_hits(0);
        report_test("no hits", errs);
        errs = errors;
        hit_offs = {5, 6, 7, 50, 90, 120, 180};
        test_hits(0);
        report_test("seven hits", errs);
        errs = errors;
        test_ready_hold();
        report_test("ready held low", errs);
        errs = errors;
        test_ignored_inputs();
        report_test("ignored hit and start", errs);

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tdc_coarse_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_coarse_counter #(
    parameter int RANGE_COUNT = 10000
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          window_clear,  // start accepted
    input  wire                          window_run,    // high through MEASURE
    output logic [tdc_pkg::COARSE_W-1:0] coarse,
    output logic                         window_done
);
    import tdc_pkg::*;

    localparam logic [COARSE_W-1:0] LIMIT = COARSE_W'(RANGE_COUNT);

    logic at_limit;

    assign at_limit    = (coarse == LIMIT);
    assign window_done = at_limit;  // level, stays up until the next clear

    // --------------------------------------------------
    // range timer
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coarse <= '0;
        end else if (window_clear) begin
            coarse <= '0;               // first MEASURE cycle reads 0
        end else if (window_run && !at_limit) begin
            coarse <= coarse + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: tdc_hit_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_hit_capture #(
    parameter int MAX_HITS = 5
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            start,
    input  wire                            hit,
    input  wire                            stamp_start,
    input  wire                            hit_enable,
    input  wire  [tdc_pkg::PHASE_W-1:0]    phase,
    input  wire  [tdc_pkg::COARSE_W-1:0]   coarse,
    output logic [tdc_pkg::NUM_W-1:0]      hit_count,
    output tdc_pkg::hit_stamp_t            start_stamp,
    output tdc_pkg::hit_stamp_t            hit_stamps [MAX_HITS]
);
    import tdc_pkg::*;

    logic               hit_q;     // hit sampled inside the window
    logic [PHASE_W-1:0] phase_q;   // phase taken with it
    logic               hit_write;
    hit_stamp_t         hit_now;

    // --------------------------------------------------
    // fine decode
    // --------------------------------------------------
    // two steps per set phase bit, 16 ones would give 32
    function automatic logic [FINE_W-1:0] fine_of(input logic [PHASE_W-1:0] ph);
        logic [FINE_W-1:0] ones;
        ones = '0;
        for (int i = 0; i < PHASE_W; i++) begin
            ones = ones + FINE_W'(ph[i]);
        end
        if (ones >= FINE_W'(PHASE_W)) begin
            return '1;                  // capped at 31
        end
        return {ones[FINE_W-2:0], 1'b0};
    endfunction

    // --------------------------------------------------
    // input sampling
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit & hit_enable;
        end
    end

    always_ff @(posedge clk) begin
        phase_q <= phase;
    end

    // counter has moved one step since the sample, so it reads N here
    assign hit_now.coarse = coarse;
    assign hit_now.fine   = fine_of(phase_q);

    assign hit_write = hit_q && hit_enable && (hit_count < MAX_HITS);

    // --------------------------------------------------
    // stamp register file
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_count <= '0;
        end else if (stamp_start) begin
            hit_count <= '0;
        end else if (hit_write) begin
            hit_count <= hit_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (stamp_start && start) begin
            start_stamp.coarse <= '0;          // count restarts this cycle
            start_stamp.fine   <= fine_of(phase);
        end
        if (hit_write) begin
            hit_stamps[hit_count] <= hit_now;  // next free slot
        end
    end

endmodule

`default_nettype wire

// File: tdc_pkg.sv
`default_nettype none

package tdc_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int COARSE_W = 14;                 // coarse cycle count
    localparam int FINE_W   = 5;                  // fine value, 0..31
    localparam int PHASE_W  = 16;                 // thermometer phase word
    localparam int TOF_W    = COARSE_W + FINE_W;  // one result word
    localparam int NUM_W    = 3;                  // hit count

    // sent alone when a run saw no hit
    localparam logic [TOF_W-1:0] NO_HIT_WORD = '1;

    // --------------------------------------------------
    // stamp and result types
    // --------------------------------------------------

    // one time stamp, coarse in the upper bits
    typedef struct packed {
        logic [COARSE_W-1:0] coarse;
        logic [FINE_W-1:0]   fine;
    } hit_stamp_t;

    // a result as one number, or split back into cycles plus fine part
    typedef union packed {
        logic [TOF_W-1:0] raw;
        hit_stamp_t       stamp;
    } tof_word_u;

    // --------------------------------------------------
    // readout sequence
    // --------------------------------------------------
    typedef enum logic [2:0] {
        IDLE,      // waiting for start
        MEASURE,   // window open, hits stamped
        CALC,      // one subtraction per hit
        OFFER,     // results ready, wait for tof_ready
        SEND       // burst out
    } fsm_state_t;

endpackage

`default_nettype wire

// File: tdc_readout_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_readout_fsm #(
    parameter int MAX_HITS = 5
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start,
    input  wire                        window_done,
    input  wire                        tof_ready,
    input  wire  [tdc_pkg::NUM_W-1:0]  hit_count,
    output logic                       window_clear,
    output logic                       window_run,
    output logic                       stamp_start,
    output logic                       hit_enable,
    output logic                       calc_strobe,
    output logic [tdc_pkg::NUM_W-1:0]  calc_index,
    output logic [tdc_pkg::NUM_W-1:0]  out_index,
    output logic                       tof_valid,
    output logic                       tof_last,
    output logic [tdc_pkg::NUM_W-1:0]  tof_num,
    output logic                       busy,
    output logic                       no_hit
);
    import tdc_pkg::*;

    fsm_state_t       state;
    logic [NUM_W-1:0] idx;       // slot in CALC, next word in OFFER/SEND
    logic [NUM_W-1:0] last_idx;  // last slot of the burst
    logic             load_word;

    // --------------------------------------------------
    // decoded controls
    // --------------------------------------------------
    assign no_hit   = (hit_count == '0);
    assign last_idx = no_hit ? '0 : hit_count - 1'b1;

    assign window_clear = (state == IDLE) && start;  // start only counts in IDLE
    assign stamp_start  = window_clear;
    assign window_run   = (state == MEASURE);
    assign hit_enable   = (state == MEASURE) && (hit_count < MAX_HITS);

    assign calc_strobe = (state == CALC) && !no_hit;
    assign calc_index  = idx;
    assign out_index   = idx;

    // first word once ready is seen, then one per cycle until last
    assign load_word = ((state == OFFER) && tof_ready) ||
                       ((state == SEND) && !tof_last);

    // --------------------------------------------------
    // state, index and output registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            idx       <= '0;
            tof_valid <= 1'b0;
            tof_last  <= 1'b0;
            tof_num   <= '0;
            busy      <= 1'b0;
        end else begin
            if (load_word) begin
                tof_valid <= 1'b1;
                tof_last  <= (idx == last_idx);
                tof_num   <= hit_count;
                if (idx != last_idx) begin
                    idx <= idx + 1'b1;
                end
            end

            case (state)
                IDLE: begin
                    if (start) begin
                        state <= MEASURE;
                        idx   <= '0;
                        busy  <= 1'b1;
                    end
                end
                MEASURE: begin
                    if (window_done) begin
                        state <= CALC;     // hit_count frozen from here
                    end
                end
                CALC: begin
                    if (idx == last_idx) begin
                        state <= OFFER;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                OFFER: begin
                    if (tof_ready) begin
                        state <= SEND;     // ready ignored after this
                    end
                end
                SEND: begin
                    if (tof_last) begin
                        state     <= IDLE;
                        idx       <= '0;
                        tof_valid <= 1'b0;
                        tof_last  <= 1'b0;
                        tof_num   <= '0;
                        busy      <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tdc_tof_calc.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_tof_calc #(
    parameter int MAX_HITS = 5
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        calc_strobe,
    input  wire  [tdc_pkg::NUM_W-1:0]  calc_index,
    input  wire  [tdc_pkg::NUM_W-1:0]  out_index,
    input  wire  tdc_pkg::hit_stamp_t  start_stamp,
    input  wire  tdc_pkg::hit_stamp_t  hit_stamps [MAX_HITS],
    output tdc_pkg::tof_word_u         out_word
);
    import tdc_pkg::*;

    tof_word_u start_w;
    tof_word_u stop_w;
    tof_word_u diff_w;
    tof_word_u result_buf [MAX_HITS];

    // --------------------------------------------------
    // stop minus start
    // --------------------------------------------------
    always_comb begin
        start_w.stamp = start_stamp;
        stop_w.stamp  = hit_stamps[calc_index];
        diff_w.raw    = stop_w.raw - start_w.raw;  // wraps mod 2^19
    end

    // --------------------------------------------------
    // result buffer, one slot per hit
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MAX_HITS; i++) begin
                result_buf[i] <= '0;
            end
        end else if (calc_strobe) begin
            result_buf[calc_index] <= diff_w;
        end
    end

    assign out_word = result_buf[out_index];  // no delay, top registers it

endmodule

`default_nettype wire

// File: tdc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_top #(
    parameter int MAX_HITS    = 5,
    parameter int RANGE_COUNT = 10000
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,      // arms the window
    input  wire                         hit,        // from comparator
    input  wire  [tdc_pkg::PHASE_W-1:0] phase,      // thermometer phase
    output logic [tdc_pkg::TOF_W-1:0]   tof_data,
    output logic [tdc_pkg::NUM_W-1:0]   tof_num,
    output logic                        tof_last,
    output logic                        tof_valid,
    output logic                        busy,
    input  wire                         tof_ready
);
    import tdc_pkg::*;

    logic                window_clear;
    logic                window_run;
    logic                window_done;
    logic [COARSE_W-1:0] coarse;
    logic                stamp_start;
    logic                hit_enable;
    logic [NUM_W-1:0]    hit_count;
    hit_stamp_t          start_stamp;
    hit_stamp_t          hit_stamps [MAX_HITS];
    logic                calc_strobe;
    logic [NUM_W-1:0]    calc_index;
    logic [NUM_W-1:0]    out_index;
    tof_word_u           out_word;
    logic                no_hit;

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------
    tdc_coarse_counter #(
        .RANGE_COUNT (RANGE_COUNT)
    ) u_coarse (
        .clk          (clk),
        .rst_n        (rst_n),
        .window_clear (window_clear),
        .window_run   (window_run),
        .coarse       (coarse),
        .window_done  (window_done)
    );

    tdc_hit_capture #(
        .MAX_HITS (MAX_HITS)
    ) u_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .hit         (hit),
        .stamp_start (stamp_start),
        .hit_enable  (hit_enable),
        .phase       (phase),
        .coarse      (coarse),
        .hit_count   (hit_count),
        .start_stamp (start_stamp),
        .hit_stamps  (hit_stamps)
    );

    tdc_tof_calc #(
        .MAX_HITS (MAX_HITS)
    ) u_calc (
        .clk         (clk),
        .rst_n       (rst_n),
        .calc_strobe (calc_strobe),
        .calc_index  (calc_index),
        .out_index   (out_index),
        .start_stamp (start_stamp),
        .hit_stamps  (hit_stamps),
        .out_word    (out_word)
    );

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    tdc_readout_fsm #(
        .MAX_HITS (MAX_HITS)
    ) u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .window_done  (window_done),
        .tof_ready    (tof_ready),
        .hit_count    (hit_count),
        .window_clear (window_clear),
        .window_run   (window_run),
        .stamp_start  (stamp_start),
        .hit_enable   (hit_enable),
        .calc_strobe  (calc_strobe),
        .calc_index   (calc_index),
        .out_index    (out_index),
        .tof_valid    (tof_valid),
        .tof_last     (tof_last),
        .tof_num      (tof_num),
        .busy         (busy),
        .no_hit       (no_hit)
    );

    // follows out_index, lines up with tof_valid one cycle later
    always_ff @(posedge clk) begin
        tof_data <= no_hit ? NO_HIT_WORD : out_word.raw;
    end

endmodule

`default_nettype wire
